/* riscvPipe.f */
riscvPkg.sv
riscvIfs.sv
fetchStage.sv
decodeStage.sv
hazardCtrl.sv
executeStage.sv
memWbStage.sv
riscvTop.sv
tbRiscv.sv

/* Makefile */
TOOL = verilator
FLAGS = --binary --assert --timing
TOP = tbRiscv
FILELIST = riscvPipe.f
OBJDIR = obj_dir

.PHONY: all compile run clean

all: run

compile:
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(OBJDIR)

run: compile
	@out="$$(./$(OBJDIR)/V$(TOP))"; echo "$$out"; echo "$$out" | grep -qx "Done: no errors"

clean:
	rm -rf $(OBJDIR)

/* tbRiscv.sv */
`timescale 1ns/1ns
`default_nettype none

module tbRiscv;

	localparam riscvPkg::iAddr_t resetPc = 12'h100;
	// Word index of the first program word
	localparam int baseWord = int'(resetPc) / 4;
	localparam int testCount = 5;
	// Every test ends far below this budget
	localparam int cycleLimit = testCount * 400;

	logic CLK = 1'b0;
	logic RSTn;
	logic iMemCsn;
	riscvPkg::instr_t iMemDi;
	riscvPkg::iAddr_t iMemAddr;
	logic dMemCsn;
	riscvPkg::word_t dMemDi;
	riscvPkg::word_t dMemDout;
	riscvPkg::dAddr_t dMemAddr;
	logic dMemWen;
	logic rfWe;
	riscvPkg::regAddr_t rfRa1, rfRa2, rfWa;
	riscvPkg::word_t rfRd1, rfRd2, rfWd;
	logic halt;
	riscvPkg::word_t numInst;

	// Memory and register-file models
	riscvPkg::instr_t iMem [0:1023];
	riscvPkg::word_t dMem [0:1023];
	riscvPkg::word_t rf [0:31];

	// Program is staged here and copied into iMem at a load edge
	riscvPkg::instr_t progBuf [0:63];
	int progLen;
	logic loadReq;

	int errorCount;
	int checkCount;
	int cycleCount = 0;
	logic [31:0] lcgState;

	riscvTop #(.resetPc(resetPc)) UUT (.*);

	always #20 CLK = ~CLK;

	// Combinational reads
	assign iMemDi = iMem[iMemAddr[11:2]];
	assign dMemDi = dMem[dMemAddr];
	assign rfRd1 = rf[rfRa1];
	assign rfRd2 = rf[rfRa2];

	// Start value of each register, x0 always zero
	function automatic riscvPkg::word_t rfInit(input riscvPkg::regAddr_t r);
		return (r == 5'd0) ? 32'd0 : (32'hbee00000 | {27'b0, r});
	endfunction

	// Writes, or a fresh load of all models while in reset
	always @(posedge CLK) begin
		if (loadReq) begin
			for (int i = 0; i < 1024; i++) begin
				if (i >= baseWord && i < baseWord + progLen) begin
					iMem[i] <= progBuf[i - baseWord];
				end else begin
					// ADDI x0,x0,i so stray fetches change nothing
					iMem[i] <= {2'b00, 10'(i), 20'h00013};
				end
				dMem[i] <= 32'hd5a00000 | 32'(i);
			end
			for (int r = 0; r < 32; r++) begin
				rf[r] <= rfInit(5'(r));
			end
		end else begin
			if (rfWe && rfWa != 5'd0) begin
				rf[rfWa] <= rfWd;
			end
			// Store strobes are active low
			if (!dMemCsn && !dMemWen) begin
				dMem[dMemAddr] <= dMemDout;
			end
		end
	end

	always @(posedge CLK) begin
		cycleCount <= cycleCount + 1;
		if (cycleCount >= cycleLimit) begin
			$display("Timeout: halt did not arrive within %0d cycles", cycleLimit);
			$display("Checks run: %0d, errors: %0d", checkCount, errorCount);
			$display("Done: errors found");
			$finish;
		end
	end

	// LCG step, top bits give a 12-bit immediate
	function automatic logic [11:0] randomImm();
		lcgState = lcgState * 32'd1664525 + 32'd1013904223;
		return lcgState[31:20];
	endfunction

	function automatic riscvPkg::word_t sext12(input logic [11:0] v);
		return {{20{v[11]}}, v};
	endfunction

	function automatic riscvPkg::word_t pcOf(input int k);
		return {20'b0, resetPc} + 32'(4 * k);
	endfunction

	// RV32I encoders
	function automatic riscvPkg::instr_t rOp(input logic [6:0] f7, input logic [2:0] f3,
		input riscvPkg::regAddr_t rd, input riscvPkg::regAddr_t rs1,
		input riscvPkg::regAddr_t rs2);
		return {f7, rs2, rs1, f3, rd, 7'b0110011};
	endfunction

	function automatic riscvPkg::instr_t iOp(input logic [6:0] op, input logic [2:0] f3,
		input riscvPkg::regAddr_t rd, input riscvPkg::regAddr_t rs1, input logic [11:0] imm);
		return {imm, rs1, f3, rd, op};
	endfunction

	function automatic riscvPkg::instr_t addi(input riscvPkg::regAddr_t rd,
		input riscvPkg::regAddr_t rs1, input logic [11:0] imm);
		return iOp(7'b0010011, 3'b000, rd, rs1, imm);
	endfunction

	function automatic riscvPkg::instr_t sw(input riscvPkg::regAddr_t rs2,
		input riscvPkg::regAddr_t rs1, input logic [11:0] imm);
		return {imm[11:5], rs2, rs1, 3'b010, imm[4:0], 7'b0100011};
	endfunction

	// Branch offset is in bytes, bit 0 dropped
	function automatic riscvPkg::instr_t branch(input logic [2:0] f3,
		input riscvPkg::regAddr_t rs1, input riscvPkg::regAddr_t rs2, input logic [12:0] off);
		return {off[12], off[10:5], rs2, rs1, f3, off[4:1], off[11], 7'b1100011};
	endfunction

	function automatic riscvPkg::instr_t jal(input riscvPkg::regAddr_t rd,
		input logic [20:0] off);
		return {off[20], off[10:1], off[11], off[19:12], rd, 7'b1101111};
	endfunction

	task automatic emit(input riscvPkg::instr_t w);
		progBuf[progLen] = w;
		progLen++;
	endtask

	// ADDI x1,x0,12 then JALR x0,0(x1)
	task automatic emitHalt();
		emit(addi(5'd1, 5'd0, 12'd12));
		emit(iOp(7'b1100111, 3'b000, 5'd0, 5'd1, 12'd0));
	endtask

	task automatic checkWord(input string name, input riscvPkg::word_t expected,
		input riscvPkg::word_t actual);
		checkCount++;
		if (actual !== expected) begin
			errorCount++;
			$display("CHECK FAILED %s: expected %h, actual %h", name, expected, actual);
		end
	endtask

	task automatic checkAddr(input string name, input riscvPkg::iAddr_t expected,
		input riscvPkg::iAddr_t actual);
		checkCount++;
		if (actual !== expected) begin
			errorCount++;
			$display("CHECK FAILED %s: expected %h, actual %h", name, expected, actual);
		end
	endtask

	task automatic checkBit(input string name, input logic expected, input logic actual);
		checkCount++;
		if (actual !== expected) begin
			errorCount++;
			$display("CHECK FAILED %s: expected %b, actual %b", name, expected, actual);
		end
	endtask

	task automatic checkReg(input string name, input riscvPkg::regAddr_t idx,
		input riscvPkg::word_t expected);
		checkCount++;
		if (rf[idx] !== expected) begin
			errorCount++;
			$display("CHECK FAILED %s x%0d: expected %h, actual %h",
				name, idx, expected, rf[idx]);
		end
	endtask

	// Reset held for 16 cycles while the models are reloaded
	task automatic pulseReset(input string name);
		@(posedge CLK);
		RSTn <= 1'b1;
		loadReq <= 1'b1;
		for (int i = 0; i < 16; i++) begin
			@(posedge CLK);
			loadReq <= 1'b0;
			@(negedge CLK);
			checkBit({name, " rfWe in reset"}, 1'b0, rfWe);
			checkBit({name, " dMemWen in reset"}, 1'b1, dMemWen);
			checkBit({name, " dMemCsn in reset"}, 1'b1, dMemCsn);
			checkBit({name, " iMemCsn in reset"}, 1'b1, iMemCsn);
			checkBit({name, " halt in reset"}, 1'b0, halt);
			checkWord({name, " numInst in reset"}, 32'd0, numInst);
		end
		@(posedge CLK);
		RSTn <= 1'b0;
	endtask

	// Halt is a one-cycle pulse, JALR retires two edges after it
	task automatic runToHalt(input string name, input riscvPkg::word_t expectedCount);
		while (halt !== 1'b1) begin
			@(negedge CLK);
		end
		@(negedge CLK);
		checkBit({name, " halt pulse"}, 1'b0, halt);
		@(negedge CLK);
		checkWord({name, " numInst"}, expectedCount, numInst);
	endtask

	task automatic resetTest();
		progLen = 0;
		emitHalt();
		pulseReset("reset");
		// PC still parked on the first edge without reset
		@(negedge CLK);
		@(negedge CLK);
		checkAddr("reset first fetch", resetPc, iMemAddr);
		checkBit("reset fetch select", 1'b0, iMemCsn);
		runToHalt("reset", 32'd2);
		checkReg("reset", 5'd1, 32'd12);
	endtask

	// Back-to-back dependences hit every forwarding path
	task automatic aluTest();
		logic [11:0] imm1, imm2, imm3;
		riscvPkg::word_t e5, e6, e7, e8, e9, e10, e11, e12, e13, e14;
		imm1 = randomImm();
		imm2 = randomImm();
		imm3 = randomImm();
		progLen = 0;
		emit(addi(5'd5, 5'd0, imm1));
		emit(addi(5'd6, 5'd5, imm2));
		emit(rOp(7'h00, 3'b000, 5'd7, 5'd5, 5'd6));
		// SUB reads x5 through the decode bypass
		emit(rOp(7'h20, 3'b000, 5'd8, 5'd5, 5'd7));
		emit(rOp(7'h00, 3'b100, 5'd9, 5'd8, 5'd6));
		emit(rOp(7'h00, 3'b110, 5'd10, 5'd9, 5'd7));
		emit(rOp(7'h00, 3'b111, 5'd11, 5'd10, 5'd5));
		emit(rOp(7'h00, 3'b010, 5'd12, 5'd5, 5'd6));
		emit(rOp(7'h00, 3'b010, 5'd13, 5'd6, 5'd5));
		emit(addi(5'd14, 5'd12, imm3));
		emitHalt();
		e5 = sext12(imm1);
		e6 = e5 + sext12(imm2);
		e7 = e5 + e6;
		e8 = e5 - e7;
		e9 = e8 ^ e6;
		e10 = e9 | e7;
		e11 = e10 & e5;
		e12 = ($signed(e5) < $signed(e6)) ? 32'd1 : 32'd0;
		e13 = ($signed(e6) < $signed(e5)) ? 32'd1 : 32'd0;
		e14 = e12 + sext12(imm3);
		pulseReset("alu");
		runToHalt("alu", 32'd12);
		checkReg("alu", 5'd5, e5);
		checkReg("alu", 5'd6, e6);
		checkReg("alu", 5'd7, e7);
		checkReg("alu", 5'd8, e8);
		checkReg("alu", 5'd9, e9);
		checkReg("alu", 5'd10, e10);
		checkReg("alu", 5'd11, e11);
		checkReg("alu", 5'd12, e12);
		checkReg("alu", 5'd13, e13);
		checkReg("alu", 5'd14, e14);
	endtask

	task automatic loadStoreTest();
		logic [11:0] value;
		riscvPkg::word_t e5, e8;
		value = randomImm();
		e5 = sext12(value);
		e8 = e5 + e5;
		progLen = 0;
		emit(addi(5'd5, 5'd0, value));
		emit(addi(5'd6, 5'd0, 12'h040));
		emit(sw(5'd5, 5'd6, 12'd8));
		emit(iOp(7'b0000011, 3'b010, 5'd7, 5'd6, 12'd8));
		// Load-use, one bubble each
		emit(rOp(7'h00, 3'b000, 5'd8, 5'd7, 5'd5));
		emit(sw(5'd8, 5'd6, 12'd12));
		emit(iOp(7'b0000011, 3'b010, 5'd9, 5'd6, 12'd12));
		emit(addi(5'd10, 5'd9, 12'd1));
		emitHalt();
		pulseReset("loadStore");
		runToHalt("loadStore", 32'd10);
		// Byte 0x48 is word 18, byte 0x4c is word 19
		checkWord("loadStore mem word 18", e5, dMem[18]);
		checkWord("loadStore mem word 19", e8, dMem[19]);
		checkReg("loadStore", 5'd7, e5);
		checkReg("loadStore", 5'd8, e8);
		checkReg("loadStore", 5'd9, e8);
		checkReg("loadStore", 5'd10, e8 + 32'd1);
	endtask

	// x20..x27 sit in shadows of taken transfers
	task automatic controlTest();
		logic [11:0] oddTarget;
		oddTarget = 12'(pcOf(19) + 32'd1);
		progLen = 0;
		emit(addi(5'd5, 5'd0, 12'd7));
		emit(addi(5'd6, 5'd0, 12'd7));
		emit(branch(3'b000, 5'd5, 5'd6, 13'd12));
		emit(addi(5'd20, 5'd0, 12'd1));
		emit(addi(5'd21, 5'd0, 12'd1));
		emit(branch(3'b001, 5'd5, 5'd6, 13'd12));
		emit(addi(5'd7, 5'd0, 12'd3));
		emit(branch(3'b001, 5'd5, 5'd7, 13'd12));
		emit(addi(5'd22, 5'd0, 12'd1));
		emit(addi(5'd23, 5'd0, 12'd1));
		emit(branch(3'b000, 5'd5, 5'd7, 13'd8));
		emit(addi(5'd8, 5'd0, 12'd5));
		emit(jal(5'd9, 21'd12));
		emit(addi(5'd24, 5'd0, 12'd1));
		emit(addi(5'd25, 5'd0, 12'd1));
		// Odd target, JALR must land on the even word
		emit(addi(5'd10, 5'd0, oddTarget));
		emit(iOp(7'b1100111, 3'b000, 5'd11, 5'd10, 12'd0));
		emit(addi(5'd26, 5'd0, 12'd1));
		emit(addi(5'd27, 5'd0, 12'd1));
		// Link shows the landing pc, an odd one would leak into x13
		emit(jal(5'd13, 21'd4));
		emit(addi(5'd12, 5'd11, 12'd0));
		emitHalt();
		pulseReset("control");
		runToHalt("control", 32'd15);
		checkReg("control", 5'd7, 32'd3);
		checkReg("control", 5'd8, 32'd5);
		checkReg("control", 5'd9, pcOf(13));
		checkReg("control", 5'd10, sext12(oddTarget));
		checkReg("control", 5'd11, pcOf(17));
		checkReg("control", 5'd12, pcOf(17));
		checkReg("control", 5'd13, pcOf(20));
		for (int r = 20; r < 28; r++) begin
			checkReg("control shadow", 5'(r), rfInit(5'(r)));
		end
	endtask

	// A lone first halt word must not stop anything
	task automatic haltTest();
		progLen = 0;
		emit(addi(5'd1, 5'd0, 12'd12));
		emit(addi(5'd5, 5'd1, 12'd1));
		emit(rOp(7'h00, 3'b000, 5'd6, 5'd5, 5'd1));
		emitHalt();
		pulseReset("halt");
		runToHalt("halt", 32'd5);
		checkReg("halt", 5'd1, 32'd12);
		checkReg("halt", 5'd5, 32'd13);
		checkReg("halt", 5'd6, 32'd25);
	endtask

	initial begin
		RSTn = 1'b1;
		loadReq = 1'b0;
		progLen = 0;
		errorCount = 0;
		checkCount = 0;
		lcgState = 32'hbcbc2c77;
		resetTest();
		aluTest();
		loadStoreTest();
		controlTest();
		haltTest();
		$display("Checks run: %0d, errors: %0d", checkCount, errorCount);
		if (errorCount == 0) begin
			$display("Done: no errors");
		end else begin
			$display("Done: errors found");
		end
		$finish;
	end

endmodule

`default_nettype wire

/* riscvTop.sv */
`timescale 1ns/1ns
`default_nettype none

module riscvTop #(
	parameter riscvPkg::iAddr_t resetPc = '0
) (
	input wire CLK,
	input wire RSTn,
	output logic iMemCsn,
	input wire riscvPkg::instr_t iMemDi,
	output riscvPkg::iAddr_t iMemAddr,
	output logic dMemCsn,
	input wire riscvPkg::word_t dMemDi,
	output riscvPkg::word_t dMemDout,
	output riscvPkg::dAddr_t dMemAddr,
	output logic dMemWen,
	output logic rfWe,
	output riscvPkg::regAddr_t rfRa1,
	output riscvPkg::regAddr_t rfRa2,
	output riscvPkg::regAddr_t rfWa,
	input wire riscvPkg::word_t rfRd1,
	input wire riscvPkg::word_t rfRd2,
	output riscvPkg::word_t rfWd,
	output logic halt,
	output riscvPkg::word_t numInst
);
	// Hazard and redirect strobes
	wire stall, redirect;
	wire riscvPkg::iAddr_t redirectPc;
	wire riscvPkg::fwdSel_e fwdA, fwdB;

	// IF/ID
	wire riscvPkg::instr_t ifIdInstr;
	wire riscvPkg::iAddr_t ifIdPc;
	wire ifIdRs1Used, ifIdRs2Used;

	// ID/EX
	wire riscvPkg::regAddr_t idExRs1, idExRs2, idExRd;
	wire idExRs1Used, idExRs2Used;
	wire idExMemRead, idExMemWrite, idExRegWrite, idExValid;
	wire idExBranch, idExBranchNe, idExJump, idExJalr;
	wire riscvPkg::aluOp_e idExAluOp;
	wire riscvPkg::srcA_e idExSrcA;
	wire riscvPkg::srcB_e idExSrcB;
	wire riscvPkg::wbSel_e idExWbSel;
	wire riscvPkg::word_t idExA, idExB, idExImm;
	wire riscvPkg::iAddr_t idExPc;
	wire riscvPkg::instr_t idExInstr;

	// EX/MEM and writeback bundles
	memStageIf mem ();
	wbIf wb ();

	fetchStage #(.resetPc(resetPc)) fetch (.*);
	decodeStage decode (.*);
	// IF/ID source indexes are the register file read addresses
	hazardCtrl hazard (.*, .ifIdRs1(rfRa1), .ifIdRs2(rfRa2));
	executeStage execute (.*);
	memWbStage memWb (.*);

endmodule

`default_nettype wire

/* memWbStage.sv */
`timescale 1ns/1ns
`default_nettype none

module memWbStage (
	input wire CLK,
	input wire RSTn,
	memStageIf.memIn mem,
	input wire riscvPkg::word_t dMemDi,
	output riscvPkg::dAddr_t dMemAddr,
	output riscvPkg::word_t dMemDout,
	output logic dMemCsn,
	output logic dMemWen,
	wbIf.wbOut wb,
	output logic rfWe,
	output riscvPkg::regAddr_t rfWa,
	output riscvPkg::word_t rfWd,
	output logic halt,
	output riscvPkg::word_t numInst
);
	riscvPkg::wbSel_e wbSelR;
	riscvPkg::word_t aluR, loadR, pc4R;
	riscvPkg::instr_t prevMemInstr;

	// Byte address from the ALU, memory is word addressed
	assign dMemAddr = mem.aluResult[11:2];
	assign dMemDout = mem.storeData;
	// Both strobes are active low
	assign dMemCsn = !(mem.valid && (mem.memRead || mem.memWrite));
	assign dMemWen = !(mem.valid && mem.memWrite);

	// MEM/WB control
	always_ff @(posedge CLK) begin
		if (RSTn) begin
			wb.valid <= 1'b0;
			wb.regWrite <= 1'b0;
		end else begin
			wb.valid <= mem.valid;
			wb.regWrite <= mem.regWrite;
		end
	end

	// MEM/WB data, load word captured here
	always_ff @(posedge CLK) begin
		wb.rd <= mem.rd;
		wbSelR <= mem.wbSel;
		aluR <= mem.aluResult;
		loadR <= dMemDi;
		pc4R <= mem.pc4;
	end

	always_comb begin
		case (wbSelR)
			riscvPkg::wbMem: wb.data = loadR;
			riscvPkg::wbPc4: wb.data = pc4R;
			default: wb.data = aluR;
		endcase
	end

	assign rfWe = wb.regWrite;
	assign rfWa = wb.rd;
	assign rfWd = wb.data;

	// Retired count skips bubbles
	always_ff @(posedge CLK) begin
		if (RSTn) begin
			numInst <= '0;
		end else if (wb.valid) begin
			numInst <= numInst + 32'd1;
		end
	end

	// Word seen in memory on the previous cycle
	always_ff @(posedge CLK) begin
		if (RSTn) begin
			prevMemInstr <= riscvPkg::nopInstr;
		end else begin
			prevMemInstr <= mem.valid ? mem.instr : riscvPkg::nopInstr;
		end
	end

	assign halt = mem.valid && (mem.instr == riscvPkg::haltSecondInstr)
		&& (prevMemInstr == riscvPkg::haltFirstInstr);

	noReadWrite: assert property (@(posedge CLK) disable iff (RSTn)
		!(mem.memRead && mem.memWrite));

endmodule

`default_nettype wire

/* executeStage.sv */
`timescale 1ns/1ns
`default_nettype none

module executeStage (
	input wire CLK,
	input wire RSTn,
	input wire riscvPkg::regAddr_t idExRd,
	input wire idExMemRead,
	input wire idExMemWrite,
	input wire idExRegWrite,
	input wire idExValid,
	input wire idExBranch,
	input wire idExBranchNe,
	input wire idExJump,
	input wire idExJalr,
	input wire riscvPkg::aluOp_e idExAluOp,
	input wire riscvPkg::srcA_e idExSrcA,
	input wire riscvPkg::srcB_e idExSrcB,
	input wire riscvPkg::wbSel_e idExWbSel,
	input wire riscvPkg::word_t idExA,
	input wire riscvPkg::word_t idExB,
	input wire riscvPkg::word_t idExImm,
	input wire riscvPkg::iAddr_t idExPc,
	input wire riscvPkg::instr_t idExInstr,
	input wire riscvPkg::fwdSel_e fwdA,
	input wire riscvPkg::fwdSel_e fwdB,
	wbIf.wbView wb,
	memStageIf.exOut mem,
	output logic redirect,
	output riscvPkg::iAddr_t redirectPc
);
	riscvPkg::word_t exMemFwd, opRs1, opRs2;
	riscvPkg::word_t aluA, aluB, aluResult, pc4;
	riscvPkg::iAddr_t branchTarget, jumpTarget;
	logic equal, taken;

	// A link in EX/MEM forwards pc+4 instead of its jump target
	assign exMemFwd = (mem.wbSel == riscvPkg::wbPc4) ? mem.pc4 : mem.aluResult;

	always_comb begin
		case (fwdA)
			riscvPkg::fwdExMem: opRs1 = exMemFwd;
			riscvPkg::fwdMemWb: opRs1 = wb.data;
			default: opRs1 = idExA;
		endcase
		case (fwdB)
			riscvPkg::fwdExMem: opRs2 = exMemFwd;
			riscvPkg::fwdMemWb: opRs2 = wb.data;
			default: opRs2 = idExB;
		endcase
	end

	assign aluA = (idExSrcA == riscvPkg::srcAPc) ? {20'b0, idExPc} : opRs1;
	assign aluB = (idExSrcB == riscvPkg::srcBImm) ? idExImm : opRs2;

	always_comb begin
		case (idExAluOp)
			riscvPkg::aluAdd: aluResult = aluA + aluB;
			riscvPkg::aluSub: aluResult = aluA - aluB;
			riscvPkg::aluAnd: aluResult = aluA & aluB;
			riscvPkg::aluOr: aluResult = aluA | aluB;
			riscvPkg::aluXor: aluResult = aluA ^ aluB;
			riscvPkg::aluSlt: aluResult = {31'b0, $signed(aluA) < $signed(aluB)};
			// passB and spare codes
			default: aluResult = aluB;
		endcase
	end

	// Branches run a subtract so zero means equal
	assign equal = (aluResult == '0);
	assign taken = idExBranch && (equal != idExBranchNe);
	assign redirect = taken || idExJump;

	assign pc4 = {20'b0, idExPc} + 32'd4;
	assign branchTarget = idExPc + idExImm[11:0];
	// JALR drops the low target bit
	assign jumpTarget = idExJalr ? {aluResult[11:1], 1'b0} : aluResult[11:0];
	assign redirectPc = idExJump ? jumpTarget : branchTarget;

	// EX/MEM control
	always_ff @(posedge CLK) begin
		if (RSTn) begin
			mem.valid <= 1'b0;
			mem.regWrite <= 1'b0;
			mem.memRead <= 1'b0;
			mem.memWrite <= 1'b0;
		end else begin
			mem.valid <= idExValid;
			mem.regWrite <= idExRegWrite;
			mem.memRead <= idExMemRead;
			mem.memWrite <= idExMemWrite;
		end
	end

	// EX/MEM data, store value taken after forwarding
	always_ff @(posedge CLK) begin
		mem.rd <= idExRd;
		mem.aluResult <= aluResult;
		mem.storeData <= opRs2;
		mem.wbSel <= idExWbSel;
		mem.pc4 <= pc4;
		mem.instr <= idExInstr;
	end

endmodule

`default_nettype wire

/* hazardCtrl.sv */
`timescale 1ns/1ns
`default_nettype none

module hazardCtrl (
	input wire CLK,
	input wire RSTn,
	input wire riscvPkg::regAddr_t ifIdRs1,
	input wire riscvPkg::regAddr_t ifIdRs2,
	input wire ifIdRs1Used,
	input wire ifIdRs2Used,
	input wire riscvPkg::regAddr_t idExRd,
	input wire idExMemRead,
	input wire riscvPkg::regAddr_t idExRs1,
	input wire riscvPkg::regAddr_t idExRs2,
	input wire idExRs1Used,
	input wire idExRs2Used,
	memStageIf.fwdView mem,
	wbIf.wbView wb,
	output logic stall,
	output riscvPkg::fwdSel_e fwdA,
	output riscvPkg::fwdSel_e fwdB
);
	logic loadHitsRs1, loadHitsRs2;

	// Load result is not ready until after memory
	// One bubble lets MEM/WB forwarding pick it up
	assign loadHitsRs1 = ifIdRs1Used && (ifIdRs1 == idExRd);
	assign loadHitsRs2 = ifIdRs2Used && (ifIdRs2 == idExRd);
	assign stall = idExMemRead && (idExRd != '0) && (loadHitsRs1 || loadHitsRs2);

	// Youngest producer wins
	function automatic riscvPkg::fwdSel_e pickSource(
		input riscvPkg::regAddr_t rs,
		input logic used
	);
		if (!used || rs == '0) begin
			return riscvPkg::fwdNone;
		end
		if (mem.regWrite && mem.rd == rs) begin
			return riscvPkg::fwdExMem;
		end
		if (wb.valid && wb.regWrite && wb.rd == rs) begin
			return riscvPkg::fwdMemWb;
		end
		return riscvPkg::fwdNone;
	endfunction

	always_comb begin
		fwdA = pickSource(idExRs1, idExRs1Used);
		fwdB = pickSource(idExRs2, idExRs2Used);
	end

	// An EX/MEM source must write now and again one stage later
	exMemSourceWrites: assert property (@(posedge CLK) disable iff (RSTn)
		fwdA == riscvPkg::fwdExMem |-> mem.regWrite ##1 wb.regWrite);

endmodule

`default_nettype wire

/* decodeStage.sv */
`timescale 1ns/1ns
`default_nettype none

module decodeStage (
	input wire CLK,
	input wire RSTn,
	input wire riscvPkg::instr_t ifIdInstr,
	input wire riscvPkg::iAddr_t ifIdPc,
	input wire stall,
	input wire redirect,
	input wire riscvPkg::word_t rfRd1,
	input wire riscvPkg::word_t rfRd2,
	wbIf.wbView wb,
	output riscvPkg::regAddr_t rfRa1,
	output riscvPkg::regAddr_t rfRa2,
	output logic ifIdRs1Used,
	output logic ifIdRs2Used,
	output riscvPkg::regAddr_t idExRs1,
	output riscvPkg::regAddr_t idExRs2,
	output logic idExRs1Used,
	output logic idExRs2Used,
	output riscvPkg::regAddr_t idExRd,
	output logic idExMemRead, idExMemWrite, idExRegWrite, idExValid,
	output logic idExBranch, idExBranchNe, idExJump, idExJalr,
	output riscvPkg::aluOp_e idExAluOp,
	output riscvPkg::srcA_e idExSrcA,
	output riscvPkg::srcB_e idExSrcB,
	output riscvPkg::wbSel_e idExWbSel,
	output riscvPkg::word_t idExA,
	output riscvPkg::word_t idExB,
	output riscvPkg::word_t idExImm,
	output riscvPkg::iAddr_t idExPc,
	output riscvPkg::instr_t idExInstr
);
	riscvPkg::regAddr_t rd;
	logic [2:0] funct3;
	logic decValid, decRegWrite, decMemRead, decMemWrite;
	logic decBranch, decJump, decJalr;
	riscvPkg::aluOp_e decAluOp;
	riscvPkg::srcA_e decSrcA;
	riscvPkg::srcB_e decSrcB;
	riscvPkg::wbSel_e decWbSel;
	riscvPkg::word_t immI, immS, immB, immJ, decImm;
	riscvPkg::word_t rs1Data, rs2Data;

	assign rd = ifIdInstr[11:7];
	assign funct3 = ifIdInstr[14:12];
	assign rfRa1 = ifIdInstr[19:15];
	assign rfRa2 = ifIdInstr[24:20];

	// Bubbles travel as the canonical NOP word
	assign decValid = (ifIdInstr != riscvPkg::nopInstr);

	// Sign-extended immediate formats
	assign immI = {{20{ifIdInstr[31]}}, ifIdInstr[31:20]};
	assign immS = {{20{ifIdInstr[31]}}, ifIdInstr[31:25], ifIdInstr[11:7]};
	assign immB = {{19{ifIdInstr[31]}}, ifIdInstr[31], ifIdInstr[7],
		ifIdInstr[30:25], ifIdInstr[11:8], 1'b0};
	assign immJ = {{11{ifIdInstr[31]}}, ifIdInstr[31], ifIdInstr[19:12],
		ifIdInstr[20], ifIdInstr[30:21], 1'b0};

	// Same-cycle register write is taken straight from writeback
	assign rs1Data = (wb.valid && wb.regWrite && wb.rd == rfRa1) ? wb.data : rfRd1;
	assign rs2Data = (wb.valid && wb.regWrite && wb.rd == rfRa2) ? wb.data : rfRd2;

	always_comb begin
		decRegWrite = 1'b0;
		decMemRead = 1'b0;
		decMemWrite = 1'b0;
		decBranch = 1'b0;
		decJump = 1'b0;
		decJalr = 1'b0;
		ifIdRs1Used = 1'b0;
		ifIdRs2Used = 1'b0;
		decAluOp = riscvPkg::aluPassB;
		decSrcA = riscvPkg::srcAReg;
		decSrcB = riscvPkg::srcBReg;
		decWbSel = riscvPkg::wbAlu;
		decImm = immI;
		case (ifIdInstr[6:0])
			riscvPkg::opR: begin
				decRegWrite = 1'b1;
				ifIdRs1Used = 1'b1;
				ifIdRs2Used = 1'b1;
				case (funct3)
					// funct7 bit 5 splits ADD from SUB
					3'b000: decAluOp = ifIdInstr[30] ? riscvPkg::aluSub : riscvPkg::aluAdd;
					3'b010: decAluOp = riscvPkg::aluSlt;
					3'b100: decAluOp = riscvPkg::aluXor;
					3'b110: decAluOp = riscvPkg::aluOr;
					3'b111: decAluOp = riscvPkg::aluAnd;
					default: decAluOp = riscvPkg::aluPassB;
				endcase
			end
			riscvPkg::opImm: begin
				decRegWrite = 1'b1;
				ifIdRs1Used = 1'b1;
				decSrcB = riscvPkg::srcBImm;
				decAluOp = riscvPkg::aluAdd;
			end
			riscvPkg::opLoad: begin
				decRegWrite = 1'b1;
				decMemRead = 1'b1;
				ifIdRs1Used = 1'b1;
				decSrcB = riscvPkg::srcBImm;
				decAluOp = riscvPkg::aluAdd;
				decWbSel = riscvPkg::wbMem;
			end
			riscvPkg::opStore: begin
				decMemWrite = 1'b1;
				ifIdRs1Used = 1'b1;
				ifIdRs2Used = 1'b1;
				decSrcB = riscvPkg::srcBImm;
				decAluOp = riscvPkg::aluAdd;
				decImm = immS;
			end
			riscvPkg::opBranch: begin
				// Equality comes from a zero difference
				decBranch = 1'b1;
				ifIdRs1Used = 1'b1;
				ifIdRs2Used = 1'b1;
				decAluOp = riscvPkg::aluSub;
				decImm = immB;
			end
			riscvPkg::opJal: begin
				// ALU forms the target from pc and offset
				decJump = 1'b1;
				decRegWrite = 1'b1;
				decSrcA = riscvPkg::srcAPc;
				decSrcB = riscvPkg::srcBImm;
				decAluOp = riscvPkg::aluAdd;
				decWbSel = riscvPkg::wbPc4;
				decImm = immJ;
			end
			riscvPkg::opJalr: begin
				decJump = 1'b1;
				decJalr = 1'b1;
				decRegWrite = 1'b1;
				ifIdRs1Used = 1'b1;
				decSrcB = riscvPkg::srcBImm;
				decAluOp = riscvPkg::aluAdd;
				decWbSel = riscvPkg::wbPc4;
			end
			default: decAluOp = riscvPkg::aluPassB;
		endcase
	end

	// Control half of ID/EX
	// Stall or redirect drops a bubble in here
	always_ff @(posedge CLK) begin
		if (RSTn || stall || redirect) begin
			idExValid <= 1'b0;
			idExRegWrite <= 1'b0;
			idExMemRead <= 1'b0;
			idExMemWrite <= 1'b0;
			idExBranch <= 1'b0;
			idExBranchNe <= 1'b0;
			idExJump <= 1'b0;
			idExJalr <= 1'b0;
			idExRs1Used <= 1'b0;
			idExRs2Used <= 1'b0;
		end else begin
			idExValid <= decValid;
			// x0 stays zero so its writes are dropped here
			idExRegWrite <= decRegWrite && (rd != '0);
			idExMemRead <= decMemRead;
			idExMemWrite <= decMemWrite;
			idExBranch <= decBranch;
			idExBranchNe <= decBranch && funct3[0];
			idExJump <= decJump;
			idExJalr <= decJalr;
			idExRs1Used <= ifIdRs1Used;
			idExRs2Used <= ifIdRs2Used;
		end
	end

	// Data half of ID/EX
	always_ff @(posedge CLK) begin
		idExRs1 <= rfRa1;
		idExRs2 <= rfRa2;
		idExRd <= rd;
		idExAluOp <= decAluOp;
		idExSrcA <= decSrcA;
		idExSrcB <= decSrcB;
		idExWbSel <= decWbSel;
		idExA <= rs1Data;
		idExB <= rs2Data;
		idExImm <= decImm;
		idExPc <= ifIdPc;
		idExInstr <= ifIdInstr;
	end

	x0NeverWritten: assert property (@(posedge CLK) disable iff (RSTn)
		idExValid && idExRegWrite |-> idExRd != '0);

endmodule

`default_nettype wire

/* fetchStage.sv */
`timescale 1ns/1ns
`default_nettype none

module fetchStage #(
	parameter riscvPkg::iAddr_t resetPc = '0
) (
	input wire CLK,
	input wire RSTn,
	input wire stall,
	input wire redirect,
	input wire riscvPkg::iAddr_t redirectPc,
	input wire riscvPkg::instr_t iMemDi,
	output riscvPkg::iAddr_t iMemAddr,
	output logic iMemCsn,
	output riscvPkg::instr_t ifIdInstr,
	output riscvPkg::iAddr_t ifIdPc
);
	riscvPkg::iAddr_t pc;
	riscvPkg::iAddr_t pcPlus4;

	assign pcPlus4 = pc + 12'd4;
	assign iMemAddr = pc;

	// Instruction memory deselected during reset
	// Select comes on one cycle after reset drops
	always_ff @(posedge CLK) begin
		if (RSTn) begin
			iMemCsn <= 1'b1;
		end else begin
			iMemCsn <= 1'b0;
		end
	end

	// Redirect from execute wins over a load-use stall
	// PC only advances once memory is selected
	always_ff @(posedge CLK) begin
		if (RSTn) begin
			pc <= resetPc;
		end else if (redirect) begin
			pc <= redirectPc;
		end else if (!stall && !iMemCsn) begin
			pc <= pcPlus4;
		end
	end

	// Wrong-path word is squashed into a bubble
	always_ff @(posedge CLK) begin
		if (RSTn || redirect) begin
			ifIdInstr <= riscvPkg::nopInstr;
		end else if (!stall) begin
			ifIdInstr <= iMemCsn ? riscvPkg::nopInstr : iMemDi;
		end
	end

	// PC rides along with its word
	always_ff @(posedge CLK) begin
		if (!stall) begin
			ifIdPc <= pc;
		end
	end

	// Younger fetch is gone the cycle after a taken transfer
	flushLeavesBubble: assert property (@(posedge CLK) disable iff (RSTn)
		redirect |=> ifIdInstr == riscvPkg::nopInstr);

endmodule

`default_nettype wire

/* riscvIfs.sv */
`timescale 1ns/1ns
`default_nettype none

// EX/MEM entry
// Memory stage consumes it and forwarding peeks at the destination
interface memStageIf;
	logic valid;
	logic regWrite;
	logic memRead;
	logic memWrite;
	riscvPkg::regAddr_t rd;
	riscvPkg::word_t aluResult;
	riscvPkg::word_t storeData;
	riscvPkg::wbSel_e wbSel;
	riscvPkg::word_t pc4;
	riscvPkg::instr_t instr;

	modport exOut (output valid, regWrite, memRead, memWrite, rd, aluResult,
		storeData, wbSel, pc4, instr);
	modport memIn (input valid, regWrite, memRead, memWrite, rd, aluResult,
		storeData, wbSel, pc4, instr);
	modport fwdView (input regWrite, rd);
endinterface

// Result leaving writeback toward the register file
interface wbIf;
	logic valid;
	logic regWrite;
	riscvPkg::regAddr_t rd;
	riscvPkg::word_t data;

	modport wbOut (output valid, regWrite, rd, data);
	modport wbView (input valid, regWrite, rd, data);
endinterface

`default_nettype wire

/* riscvPkg.sv */
`default_nettype none

package riscvPkg;

	// Data and instruction words
	typedef logic [31:0] word_t;
	typedef logic [31:0] instr_t;

	// Register file index
	typedef logic [4:0] regAddr_t;

	// Byte address into instruction memory
	typedef logic [11:0] iAddr_t;

	// Word address into data memory
	typedef logic [9:0] dAddr_t;

	// ALU operations
	// passB is the inert choice for unknown opcodes
	typedef enum logic [2:0] {
		aluAdd,
		aluSub,
		aluAnd,
		aluOr,
		aluXor,
		aluSlt,
		aluPassB
	} aluOp_e;

	// First ALU operand
	typedef enum logic {srcAReg, srcAPc} srcA_e;

	// Second ALU operand
	typedef enum logic {srcBReg, srcBImm} srcB_e;

	// Writeback source
	typedef enum logic [1:0] {wbAlu, wbMem, wbPc4} wbSel_e;

	// Operand source in execute
	typedef enum logic [1:0] {fwdNone, fwdExMem, fwdMemWb} fwdSel_e;

	// RV32I major opcodes
	localparam logic [6:0] opR = 7'b0110011;
	localparam logic [6:0] opImm = 7'b0010011;
	localparam logic [6:0] opLoad = 7'b0000011;
	localparam logic [6:0] opStore = 7'b0100011;
	localparam logic [6:0] opBranch = 7'b1100011;
	localparam logic [6:0] opJal = 7'b1101111;
	localparam logic [6:0] opJalr = 7'b1100111;

	// ADDI x0,x0,0 marks an empty slot
	localparam instr_t nopInstr = 32'h00000013;

	// Halt pair is ADDI x1,x0,12 then JALR x0,0(x1)
	localparam instr_t haltFirstInstr = 32'h00c00093;
	localparam instr_t haltSecondInstr = 32'h00008067;

endpackage

`default_nettype wire
